/* cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

`define CPU_WORD 32
`define CPU_IM_DEPTH 64
`define CPU_DM_DEPTH 64

// major opcodes, instruction bits 30:25
`define OP_BASE 6'b100000
`define OP_ADDI 6'b101000
`define OP_ORI 6'b101100
`define OP_XORI 6'b101011
`define OP_MOVI 6'b100010
`define OP_LWI 6'b000010
`define OP_SWI 6'b001010
`define OP_LS 6'b011100

// base group sub-opcodes, bits 4:0
`define SUB_ADD 5'b00000
`define SUB_SUB 5'b00001
`define SUB_AND 5'b00010
`define SUB_XOR 5'b00011
`define SUB_OR 5'b00100
`define SUB_SLLI 5'b01000
`define SUB_SRLI 5'b01001
`define SUB_ROTRI 5'b01011

// load/store group sub-opcodes, bits 7:0
`define LS_LW 8'b00000010
`define LS_SW 8'b00001010

`endif

/* cpu_pkg.sv */
`default_nettype none

`include "cpu_settings.svh"

package cpu_pkg;

	typedef struct packed {
		logic pad;
		logic [5:0] opcode;
		logic [4:0] rt;
		logic [4:0] ra;
		logic [4:0] rb;
		logic [1:0] sv;
		// ls sub-opcode, base sub-opcode is the low 5 bits
		logic [7:0] sub;
	} instr_reg_t;

	typedef struct packed {
		logic pad;
		logic [5:0] opcode;
		logic [4:0] rt;
		// ra sits in bits 19:15 for the 15-bit forms
		logic [19:0] imm20;
	} instr_imm_t;

	typedef union packed {
		instr_reg_t r;
		instr_imm_t i;
	} instr_u;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SRL,
		ALU_SLL,
		ALU_ROR
	} alu_op_e;

	typedef enum logic [1:0] {
		OPB_RB,
		OPB_IMM,
		OPB_OFFSET,
		OPB_INDEX
	} operand_e;

	typedef struct packed {
		alu_op_e alu_op;
		operand_e operand;
		logic imm_sign;
		logic result_select;
		logic reg_write;
		logic load;
		logic store;
	} ctrl_t;

	typedef struct packed {
		logic fetch;
		logic latch;
		logic execute;
		logic writeback;
		logic pc_enable;
	} phase_t;

	typedef struct packed {
		logic valid;
		logic reg_write;
		logic [4:0] dest;
		logic [`CPU_WORD-1:0] value;
		logic store;
		logic [`CPU_WORD-1:0] address;
	} retire_t;

endpackage

`default_nettype wire

/* alu.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_settings.svh"

module alu (
	input cpu_pkg::alu_op_e op,
	input logic [`CPU_WORD-1:0] a,
	input logic [`CPU_WORD-1:0] b,
	output logic [`CPU_WORD-1:0] result
);

	logic [4:0] amount;
	logic [2*`CPU_WORD-1:0] doubled;

	assign amount = b[4:0];
	// rotate by shifting two copies side by side
	assign doubled = {a, a} >> amount;

	always_comb begin
		case (op)
			cpu_pkg::ALU_ADD: begin
				result = a + b;
			end
			cpu_pkg::ALU_SUB: begin
				result = a - b;
			end
			cpu_pkg::ALU_AND: begin
				result = a & b;
			end
			cpu_pkg::ALU_OR: begin
				result = a | b;
			end
			cpu_pkg::ALU_XOR: begin
				result = a ^ b;
			end
			cpu_pkg::ALU_SRL: begin
				result = a >> amount;
			end
			cpu_pkg::ALU_SLL: begin
				result = a << amount;
			end
			cpu_pkg::ALU_ROR: begin
				result = doubled[`CPU_WORD-1:0];
			end
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* register_file.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_settings.svh"

module register_file (
	input logic clock,
	input logic reset,
	input logic [4:0] read_a,
	input logic [4:0] read_b,
	output logic [`CPU_WORD-1:0] data_a,
	output logic [`CPU_WORD-1:0] data_b,
	input logic write,
	input logic [4:0] write_reg,
	input logic [`CPU_WORD-1:0] write_data
);

	logic [`CPU_WORD-1:0] regs [32];

	// r0 is cleared by reset and never written
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (write && (write_reg != 5'd0)) begin
			regs[write_reg] <= write_data;
		end
	end

	assign data_a = regs[read_a];
	assign data_b = regs[read_b];

endmodule

`default_nettype wire

/* memory.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_settings.svh"

module memory #(
	parameter int DEPTH = 64
) (
	input logic clock,
	input logic read,
	input logic write,
	input logic [`CPU_WORD-1:0] address,
	input logic [`CPU_WORD-1:0] write_data,
	output logic [`CPU_WORD-1:0] read_data
);

	localparam int AW = $clog2(DEPTH);

	logic [`CPU_WORD-1:0] words [DEPTH];
	logic [AW-1:0] index;

	assign index = address[AW-1:0];

	// read data holds until the next read strobe
	always_ff @(posedge clock) begin
		if (write) begin
			words[index] <= write_data;
		end
		if (read) begin
			read_data <= words[index];
		end
	end

endmodule

`default_nettype wire

/* controller.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_settings.svh"

module controller (
	input logic clock,
	input logic reset,
	input cpu_pkg::instr_u instruction,
	output cpu_pkg::phase_t phase,
	output cpu_pkg::ctrl_t ctrl,
	output logic imem_read
);

	localparam logic [1:0] S_FETCH = 2'b00;
	localparam logic [1:0] S_LATCH = 2'b01;
	localparam logic [1:0] S_EXECUTE = 2'b10;
	localparam logic [1:0] S_WRITEBACK = 2'b11;

	logic [1:0] state;

	// writeback wraps back to fetch
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= S_FETCH;
		end else begin
			state <= state + 2'd1;
		end
	end

	always_comb begin
		phase.fetch = (state == S_FETCH);
		phase.latch = (state == S_LATCH);
		phase.execute = (state == S_EXECUTE);
		phase.writeback = (state == S_WRITEBACK);
		phase.pc_enable = (state == S_LATCH);
	end

	assign imem_read = phase.fetch;

	always_comb begin
		ctrl = '0;
		ctrl.alu_op = cpu_pkg::ALU_ADD;
		ctrl.operand = cpu_pkg::OPB_RB;
		case (instruction.r.opcode)
			`OP_BASE: begin
				ctrl.reg_write = 1'b1;
				case (instruction.r.sub[4:0])
					`SUB_ADD: ctrl.alu_op = cpu_pkg::ALU_ADD;
					`SUB_SUB: ctrl.alu_op = cpu_pkg::ALU_SUB;
					`SUB_AND: ctrl.alu_op = cpu_pkg::ALU_AND;
					`SUB_OR: ctrl.alu_op = cpu_pkg::ALU_OR;
					`SUB_XOR: ctrl.alu_op = cpu_pkg::ALU_XOR;
					`SUB_SRLI: begin
						ctrl.alu_op = cpu_pkg::ALU_SRL;
						ctrl.operand = cpu_pkg::OPB_IMM;
					end
					`SUB_SLLI: begin
						ctrl.alu_op = cpu_pkg::ALU_SLL;
						ctrl.operand = cpu_pkg::OPB_IMM;
					end
					`SUB_ROTRI: begin
						ctrl.alu_op = cpu_pkg::ALU_ROR;
						ctrl.operand = cpu_pkg::OPB_IMM;
					end
					default: ctrl.reg_write = 1'b0;
				endcase
			end
			`OP_ADDI: begin
				ctrl.operand = cpu_pkg::OPB_IMM;
				ctrl.imm_sign = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			`OP_ORI: begin
				ctrl.alu_op = cpu_pkg::ALU_OR;
				ctrl.operand = cpu_pkg::OPB_IMM;
				ctrl.reg_write = 1'b1;
			end
			`OP_XORI: begin
				ctrl.alu_op = cpu_pkg::ALU_XOR;
				ctrl.operand = cpu_pkg::OPB_IMM;
				ctrl.reg_write = 1'b1;
			end
			`OP_MOVI: begin
				ctrl.operand = cpu_pkg::OPB_IMM;
				ctrl.result_select = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			`OP_LWI: begin
				ctrl.operand = cpu_pkg::OPB_OFFSET;
				ctrl.load = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			`OP_SWI: begin
				ctrl.operand = cpu_pkg::OPB_OFFSET;
				ctrl.store = 1'b1;
			end
			`OP_LS: begin
				ctrl.operand = cpu_pkg::OPB_INDEX;
				case (instruction.r.sub)
					`LS_LW: begin
						ctrl.load = 1'b1;
						ctrl.reg_write = 1'b1;
					end
					`LS_SW: ctrl.store = 1'b1;
					default: ctrl.operand = cpu_pkg::OPB_RB;
				endcase
			end
			default: ctrl.reg_write = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* datapath.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_settings.svh"

module datapath (
	input logic clock,
	input logic reset,
	input cpu_pkg::phase_t phase,
	input cpu_pkg::ctrl_t ctrl,
	output cpu_pkg::instr_u instruction,
	input logic load_write,
	input logic [`CPU_WORD-1:0] load_address,
	output logic imem_write,
	output logic [`CPU_WORD-1:0] imem_address,
	input logic [`CPU_WORD-1:0] imem_data,
	output logic [`CPU_WORD-1:0] dmem_address,
	output logic dmem_read,
	output logic dmem_write,
	output logic [`CPU_WORD-1:0] dmem_write_data,
	input logic [`CPU_WORD-1:0] dmem_read_data,
	output cpu_pkg::retire_t retire
);

	cpu_pkg::instr_u fetched;
	logic [`CPU_WORD-1:0] pc;
	logic [4:0] read_b;
	logic [`CPU_WORD-1:0] data_a;
	logic [`CPU_WORD-1:0] data_b;
	logic [`CPU_WORD-1:0] store_data;
	logic [`CPU_WORD-1:0] imm15_ext;
	logic [`CPU_WORD-1:0] operand_b;
	logic [`CPU_WORD-1:0] alu_out;
	logic [`CPU_WORD-1:0] alu_q;
	logic [`CPU_WORD-1:0] result;
	logic shift_op;

	assign fetched = imem_data;
	assign imem_address = reset ? load_address : pc;
	assign imem_write = reset & load_write;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			pc <= '0;
			instruction <= '0;
		end else if (phase.pc_enable) begin
			pc <= pc + `CPU_WORD'(1);
			instruction <= fetched;
		end
	end

	// port b fetches rt while latching, so stores see three registers
	assign read_b = phase.latch ? fetched.r.rt : instruction.r.rb;

	always_ff @(posedge clock) begin
		if (phase.latch) begin
			store_data <= data_b;
		end
		if (phase.execute) begin
			alu_q <= alu_out;
		end
	end

	assign imm15_ext = ctrl.imm_sign ? {{17{instruction.i.imm20[14]}}, instruction.i.imm20[14:0]}
		: {17'b0, instruction.i.imm20[14:0]};
	assign shift_op = (ctrl.alu_op == cpu_pkg::ALU_SRL) || (ctrl.alu_op == cpu_pkg::ALU_SLL)
		|| (ctrl.alu_op == cpu_pkg::ALU_ROR);

	always_comb begin
		case (ctrl.operand)
			cpu_pkg::OPB_RB: operand_b = data_b;
			cpu_pkg::OPB_IMM: operand_b = shift_op ? {27'b0, instruction.r.rb} : imm15_ext;
			cpu_pkg::OPB_OFFSET: operand_b = {{15{instruction.i.imm20[14]}},
				instruction.i.imm20[14:0], 2'b00};
			default: operand_b = data_b << instruction.r.sv;
		endcase
	end

	alu u_alu (
		.op(ctrl.alu_op),
		.a(data_a),
		.b(operand_b),
		.result(alu_out)
	);

	register_file u_regs (
		.clock(clock),
		.reset(reset),
		.read_a(instruction.r.ra),
		.read_b(read_b),
		.data_a(data_a),
		.data_b(data_b),
		.write(phase.writeback & ctrl.reg_write),
		.write_reg(instruction.r.rt),
		.write_data(result)
	);

	// byte address to word index
	assign dmem_address = {2'b00, alu_out[`CPU_WORD-1:2]};
	assign dmem_read = phase.execute & ctrl.load;
	assign dmem_write = phase.execute & ctrl.store;
	assign dmem_write_data = store_data;

	always_comb begin
		if (ctrl.load) begin
			result = dmem_read_data;
		end else if (ctrl.result_select) begin
			result = {{12{instruction.i.imm20[19]}}, instruction.i.imm20};
		end else begin
			result = alu_q;
		end
	end

	always_comb begin
		retire.valid = phase.writeback;
		retire.reg_write = ctrl.reg_write;
		retire.dest = instruction.r.rt;
		retire.value = ctrl.store ? store_data : result;
		retire.store = ctrl.store;
		retire.address = {2'b00, alu_q[`CPU_WORD-1:2]};
	end

endmodule

`default_nettype wire

/* cpu_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_settings.svh"

module cpu_top (
	input logic clock,
	input logic reset,
	input logic load_write,
	input logic [`CPU_WORD-1:0] load_address,
	input logic [`CPU_WORD-1:0] load_data,
	output cpu_pkg::retire_t retire
);

	cpu_pkg::instr_u instruction;
	cpu_pkg::phase_t phase;
	cpu_pkg::ctrl_t ctrl;
	logic imem_read;
	logic imem_write;
	logic [`CPU_WORD-1:0] imem_address;
	logic [`CPU_WORD-1:0] imem_data;
	logic dmem_read;
	logic dmem_write;
	logic [`CPU_WORD-1:0] dmem_address;
	logic [`CPU_WORD-1:0] dmem_write_data;
	logic [`CPU_WORD-1:0] dmem_read_data;

	controller u_controller (
		.clock(clock),
		.reset(reset),
		.instruction(instruction),
		.phase(phase),
		.ctrl(ctrl),
		.imem_read(imem_read)
	);

	datapath u_datapath (
		.clock(clock),
		.reset(reset),
		.phase(phase),
		.ctrl(ctrl),
		.instruction(instruction),
		.load_write(load_write),
		.load_address(load_address),
		.imem_write(imem_write),
		.imem_address(imem_address),
		.imem_data(imem_data),
		.dmem_address(dmem_address),
		.dmem_read(dmem_read),
		.dmem_write(dmem_write),
		.dmem_write_data(dmem_write_data),
		.dmem_read_data(dmem_read_data),
		.retire(retire)
	);

	memory #(.DEPTH(`CPU_IM_DEPTH)) u_imem (
		.clock(clock),
		.read(imem_read),
		.write(imem_write),
		.address(imem_address),
		.write_data(load_data),
		.read_data(imem_data)
	);

	memory #(.DEPTH(`CPU_DM_DEPTH)) u_dmem (
		.clock(clock),
		.read(dmem_read),
		.write(dmem_write),
		.address(dmem_address),
		.write_data(dmem_write_data),
		.read_data(dmem_read_data)
	);

endmodule

`default_nettype wire

/* cpu_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_settings.svh"

module cpu_tb;

	logic clock;
	logic reset;
	logic load_write;
	logic [`CPU_WORD-1:0] load_address;
	logic [`CPU_WORD-1:0] load_data;
	cpu_pkg::retire_t retire;

	integer seed;
	int rise_count;
	int mismatch_count;
	int other_errors;
	int checked;

	logic [31:0] prog_words[$];
	string prog_names[$];

	// expected machine state
	logic [31:0] model_regs [32];
	logic [31:0] model_mem [`CPU_DM_DEPTH];

	cpu_top DUT (
		.clock(clock),
		.reset(reset),
		.load_write(load_write),
		.load_address(load_address),
		.load_data(load_data),
		.retire(retire)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#4 clock = ~clock;
		end
	end

	// rising edges since reset fell
	always @(posedge clock) begin
		if (reset) begin
			rise_count <= 0;
		end else begin
			rise_count <= rise_count + 1;
		end
	end

	function automatic logic [31:0] encode_reg(input logic [5:0] opcode, input logic [4:0] rt,
		input logic [4:0] ra, input logic [4:0] rb, input logic [1:0] sv,
		input logic [7:0] sub);
		return {1'b0, opcode, rt, ra, rb, sv, sub};
	endfunction

	function automatic logic [31:0] encode_imm(input logic [5:0] opcode, input logic [4:0] rt,
		input logic [4:0] ra, input logic [14:0] imm);
		return {1'b0, opcode, rt, ra, imm};
	endfunction

	function automatic logic [31:0] encode_movi(input logic [4:0] rt, input logic [19:0] imm);
		return {1'b0, `OP_MOVI, rt, imm};
	endfunction

	task automatic add_instr(input string name, input logic [31:0] word);
		prog_words.push_back(word);
		prog_names.push_back(name);
	endtask

	// full 32-bit constant from movi, slli by 12 and ori
	task automatic set_register(input logic [4:0] rt, input logic [31:0] value);
		add_instr("setup_movi", encode_movi(rt, value[31:12]));
		add_instr("setup_slli", encode_reg(`OP_BASE, rt, rt, 5'd12, 2'd0, {3'b0, `SUB_SLLI}));
		add_instr("setup_ori", encode_imm(`OP_ORI, rt, rt, {3'b0, value[11:0]}));
	endtask

	task automatic build_program();
		logic [31:0] rnd;
		logic [1:0] scale;
		for (int r = 1; r <= 4; r++) begin
			rnd = $random(seed);
			set_register(r, rnd);
		end
		add_instr("movi_all_ones", encode_movi(5'd5, 20'hfffff));
		add_instr("add", encode_reg(`OP_BASE, 5'd6, 5'd1, 5'd2, 2'd0, {3'b0, `SUB_ADD}));
		add_instr("sub", encode_reg(`OP_BASE, 5'd7, 5'd1, 5'd2, 2'd0, {3'b0, `SUB_SUB}));
		add_instr("and", encode_reg(`OP_BASE, 5'd8, 5'd1, 5'd2, 2'd0, {3'b0, `SUB_AND}));
		add_instr("or", encode_reg(`OP_BASE, 5'd9, 5'd3, 5'd4, 2'd0, {3'b0, `SUB_OR}));
		add_instr("xor", encode_reg(`OP_BASE, 5'd10, 5'd3, 5'd4, 2'd0, {3'b0, `SUB_XOR}));
		add_instr("add_wrap", encode_reg(`OP_BASE, 5'd11, 5'd5, 5'd3, 2'd0, {3'b0, `SUB_ADD}));

		// shift amounts sit in the rb field
		rnd = $random(seed);
		add_instr("srli", encode_reg(`OP_BASE, 5'd12, 5'd1, rnd[4:0], 2'd0, {3'b0, `SUB_SRLI}));
		add_instr("slli", encode_reg(`OP_BASE, 5'd13, 5'd2, rnd[9:5], 2'd0, {3'b0, `SUB_SLLI}));
		add_instr("rotri", encode_reg(`OP_BASE, 5'd14, 5'd3, rnd[14:10], 2'd0,
			{3'b0, `SUB_ROTRI}));
		add_instr("rotri_zero", encode_reg(`OP_BASE, 5'd15, 5'd4, 5'd0, 2'd0, {3'b0, `SUB_ROTRI}));
		add_instr("srli_zero", encode_reg(`OP_BASE, 5'd16, 5'd1, 5'd0, 2'd0, {3'b0, `SUB_SRLI}));

		rnd = $random(seed);
		add_instr("addi_negative", encode_imm(`OP_ADDI, 5'd17, 5'd1, rnd[14:0] | 15'h4000));
		add_instr("ori", encode_imm(`OP_ORI, 5'd18, 5'd2, rnd[29:15] | 15'h4000));
		rnd = $random(seed);
		add_instr("xori", encode_imm(`OP_XORI, 5'd19, 5'd3, rnd[14:0] | 15'h4000));
		add_instr("movi_negative", encode_movi(5'd20, rnd[31:12] | 20'h80000));

		// base byte address 16 in r21
		add_instr("movi_base", encode_movi(5'd21, 20'd16));
		add_instr("swi", encode_imm(`OP_SWI, 5'd1, 5'd21, 15'd3));
		add_instr("swi_negative", encode_imm(`OP_SWI, 5'd2, 5'd21, 15'h7ffe));
		add_instr("lwi", encode_imm(`OP_LWI, 5'd22, 5'd21, 15'd3));
		add_instr("lwi_negative", encode_imm(`OP_LWI, 5'd23, 5'd21, 15'h7ffe));
		add_instr("movi_index", encode_movi(5'd24, 20'd4));
		for (int s = 0; s < 4; s++) begin
			scale = s;
			add_instr($sformatf("sw_sv%0d", s),
				encode_reg(`OP_LS, 5'd3 + scale, 5'd21, 5'd24, scale, `LS_SW));
		end
		for (int s = 0; s < 4; s++) begin
			scale = s;
			add_instr($sformatf("lw_sv%0d", s),
				encode_reg(`OP_LS, 5'd25 + scale, 5'd21, 5'd24, scale, `LS_LW));
		end

		add_instr("movi_r0", encode_movi(5'd0, 20'h12345));
		add_instr("read_r0", encode_reg(`OP_BASE, 5'd29, 5'd0, 5'd0, 2'd0, {3'b0, `SUB_ADD}));
		add_instr("bad_opcode", encode_reg(6'b111111, 5'd1, 5'd2, 5'd3, 2'd0, 8'h00));
		add_instr("bad_base_sub", encode_reg(`OP_BASE, 5'd1, 5'd2, 5'd3, 2'd0, 8'h1f));
		add_instr("bad_ls_sub", encode_reg(`OP_LS, 5'd1, 5'd21, 5'd24, 2'd0, 8'hff));
		add_instr("r1_kept", encode_reg(`OP_BASE, 5'd31, 5'd1, 5'd0, 2'd0, {3'b0, `SUB_OR}));
	endtask

	// executes one instruction on the model state
	function automatic cpu_pkg::retire_t reference_step(input logic [31:0] word);
		cpu_pkg::retire_t exp;
		logic [5:0] opcode;
		logic [4:0] rt;
		logic [4:0] ra;
		logic [4:0] rb;
		logic [1:0] sv;
		logic [7:0] sub;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_s;
		logic [31:0] imm_z;
		logic [31:0] addr;
		int index;
		opcode = word[30:25];
		rt = word[24:20];
		ra = word[19:15];
		rb = word[14:10];
		sv = word[9:8];
		sub = word[7:0];
		a = model_regs[ra];
		b = model_regs[rb];
		imm_s = {{17{word[14]}}, word[14:0]};
		imm_z = {17'b0, word[14:0]};
		addr = '0;
		exp = '0;
		exp.valid = 1'b1;
		exp.dest = rt;
		case (opcode)
			`OP_BASE: begin
				exp.reg_write = 1'b1;
				case (sub[4:0])
					`SUB_ADD: exp.value = a + b;
					`SUB_SUB: exp.value = a - b;
					`SUB_AND: exp.value = a & b;
					`SUB_OR: exp.value = a | b;
					`SUB_XOR: exp.value = a ^ b;
					`SUB_SRLI: exp.value = a >> rb;
					`SUB_SLLI: exp.value = a << rb;
					`SUB_ROTRI: exp.value = (a >> rb) | (a << (6'd32 - rb));
					default: exp.reg_write = 1'b0;
				endcase
			end
			`OP_ADDI: begin
				exp.reg_write = 1'b1;
				exp.value = a + imm_s;
			end
			`OP_ORI: begin
				exp.reg_write = 1'b1;
				exp.value = a | imm_z;
			end
			`OP_XORI: begin
				exp.reg_write = 1'b1;
				exp.value = a ^ imm_z;
			end
			`OP_MOVI: begin
				exp.reg_write = 1'b1;
				exp.value = {{12{word[19]}}, word[19:0]};
			end
			`OP_LWI, `OP_SWI: begin
				addr = a + (imm_s << 2);
				exp.reg_write = (opcode == `OP_LWI);
				exp.store = (opcode == `OP_SWI);
			end
			`OP_LS: begin
				addr = a + (b << sv);
				exp.reg_write = (sub == `LS_LW);
				exp.store = (sub == `LS_SW);
			end
			default: exp.reg_write = 1'b0;
		endcase
		index = (addr >> 2) % `CPU_DM_DEPTH;
		exp.address = addr >> 2;
		if (exp.store) begin
			exp.value = model_regs[rt];
			model_mem[index] = exp.value;
		end else if (exp.reg_write && (opcode == `OP_LWI || opcode == `OP_LS)) begin
			exp.value = model_mem[index];
		end
		if (exp.reg_write && rt != 5'd0) begin
			model_regs[rt] = exp.value;
		end
		return exp;
	endfunction

	task automatic compare_retire(input string name, input cpu_pkg::retire_t exp,
		input cpu_pkg::retire_t act);
		if (act.reg_write !== exp.reg_write) begin
			$display("MISMATCH %s reg_write: expected %b actual %b", name,
				exp.reg_write, act.reg_write);
			mismatch_count++;
		end
		if (act.store !== exp.store) begin
			$display("MISMATCH %s store: expected %b actual %b", name, exp.store, act.store);
			mismatch_count++;
		end
		if (exp.reg_write && act.dest !== exp.dest) begin
			$display("MISMATCH %s dest: expected %0d actual %0d", name, exp.dest, act.dest);
			mismatch_count++;
		end
		if ((exp.reg_write || exp.store) && act.value !== exp.value) begin
			$display("MISMATCH %s value: expected %h actual %h", name, exp.value, act.value);
			mismatch_count++;
		end
		if (exp.store && act.address !== exp.address) begin
			$display("MISMATCH %s address: expected %h actual %h", name,
				exp.address, act.address);
			mismatch_count++;
		end
	endtask

	initial begin
		cpu_pkg::retire_t expected;
		int waited;
		int expected_rise;
		bit timed_out;
		reset = 1'b1;
		load_write = 1'b0;
		load_address = '0;
		load_data = '0;
		seed = 22;
		mismatch_count = 0;
		other_errors = 0;
		checked = 0;
		timed_out = 1'b0;
		for (int r = 0; r < 32; r++) begin
			model_regs[r] = '0;
		end
		build_program();

		repeat (3) @(negedge clock);
		for (int i = 0; i < prog_words.size(); i++) begin
			@(negedge clock);
			load_write = 1'b1;
			load_address = i;
			load_data = prog_words[i];
		end
		@(negedge clock);
		load_write = 1'b0;
		reset = 1'b0;

		for (int k = 0; k < prog_words.size() && !timed_out; k++) begin
			waited = 0;
			@(negedge clock);
			while (!retire.valid && waited < 20) begin
				@(negedge clock);
				waited++;
			end
			if (!retire.valid) begin
				$display("no retire record for %s within 20 cycles", prog_names[k]);
				other_errors++;
				timed_out = 1'b1;
			end else begin
				// valid after three edges, taken by the fourth
				expected_rise = 3 + 4 * k;
				if (rise_count != expected_rise) begin
					$display("MISMATCH %s retire edge: expected %0d actual %0d",
						prog_names[k], expected_rise, rise_count);
					mismatch_count++;
				end
				expected = reference_step(prog_words[k]);
				compare_retire(prog_names[k], expected, retire);
				checked++;
			end
		end

		$display("%0d retires checked, %0d mismatches, %0d other errors",
			checked, mismatch_count, other_errors);
		if (mismatch_count == 0 && other_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
+incdir+.
cpu_pkg.sv
alu.sv
register_file.sv
memory.sv
controller.sv
datapath.sv
cpu_top.sv
cpu_tb.sv
